//--- hdl/iic_pkg.sv
// I2C EEPROM master shared types
// constants, opcode and state enums, host and stage structs

package iic_pkg;

    localparam int DATA_BYTES = 2;              // data bytes per transaction
    localparam int DATA_W     = DATA_BYTES * 8; // data payload width

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } iic_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,      // bus free
        ST_DEV_WR,    // start, device address, write bit
        ST_WORD_ADDR, // one word address byte
        ST_WR_DATA,   // data bytes out
        ST_DEV_RD,    // repeated start, device address, read bit
        ST_RD_DATA,   // data bytes in
        ST_STOP       // stop condition
    } iic_state_e;

    typedef struct packed {
        iic_op_e           op;
        logic [7:0]        word_addr;
        logic [DATA_W-1:0] wdata;     // high byte goes first
    } iic_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;     // high byte was received first
        logic              ack_error; // slave missed an ack
    } iic_rsp_t;

    typedef struct packed {
        logic scl_fall; // start of bit period
        logic drive;    // quarter point, sda changes
        logic scl_rise; // half point
        logic sample;   // three quarter point, sda read
    } iic_phase_t;

    typedef struct packed {
        iic_state_e state;
        logic [3:0] bit_cnt;   // bit inside the current field
        logic [1:0] byte_cnt;  // byte inside a data field
        logic       last_byte; // final data byte
    } iic_step_t;

endpackage

//--- hdl/iic_bit_timer.sv
// I2C bit timer
// divides the system clock into bit periods and emits quarter-bit strobes

module iic_bit_timer #(
    parameter int SYS_CLK_HZ = 4_000_000,
    parameter int SCL_HZ     = 250_000
) (
    input  logic                iic_clk,
    input  logic                iic_rst,
    input  logic                run,     // sequencer busy
    output iic_pkg::iic_phase_t phase,
    output logic                bit_end  // last cycle of a bit period
);

    localparam int PERIOD = SYS_CLK_HZ / SCL_HZ; // multiple of 4, at least 8
    localparam int CNT_W  = $clog2(PERIOD);

    logic [CNT_W-1:0] cnt; // position inside the bit period

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst)
            cnt <= '0;
        else if (!run || cnt == CNT_W'(PERIOD - 1))
            cnt <= '0;                              // held at zero while idle
        else
            cnt <= cnt + 1'b1;
    end

    // strobes lag the counter by one cycle
    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            phase   <= '0;
            bit_end <= 1'b0;
        end else begin
            phase.scl_fall <= run && (cnt == '0);
            phase.drive    <= run && (cnt == CNT_W'(PERIOD / 4));
            phase.scl_rise <= run && (cnt == CNT_W'(PERIOD / 2));
            phase.sample   <= run && (cnt == CNT_W'(3 * PERIOD / 4));
            bit_end        <= run && (cnt == CNT_W'(PERIOD - 1));
        end
    end

endmodule

//--- hdl/iic_sequencer.sv
// I2C transaction sequencer
// steps through the address, data and stop fields with bit and byte counters

module iic_sequencer (
    input  logic               iic_clk,
    input  logic               iic_rst,
    input  logic               start,     // command latched by the top
    input  iic_pkg::iic_op_e   op,
    input  logic               phase_end, // end of a bit period
    output logic               run,       // keeps the bit timer going
    output iic_pkg::iic_step_t step,
    output logic               done       // leaving the stop field
);

    iic_pkg::iic_state_e state;
    iic_pkg::iic_state_e state_nxt;
    logic [3:0]          bit_cnt;
    logic [1:0]          byte_cnt;
    logic [3:0]          last_bit;   // final bit index of the current field
    logic                last_byte;
    logic                data_field;
    logic                field_end;  // final bit of the field ends now

    assign data_field = (state == iic_pkg::ST_WR_DATA) || (state == iic_pkg::ST_RD_DATA);
    assign last_byte  = data_field && (byte_cnt == 2'(iic_pkg::DATA_BYTES - 1));
    assign field_end  = phase_end && (bit_cnt == last_bit);

    assign run  = (state != iic_pkg::ST_IDLE);
    assign done = (state == iic_pkg::ST_STOP) && field_end;

    assign step.state     = state;
    assign step.bit_cnt   = bit_cnt;
    assign step.byte_cnt  = byte_cnt;
    assign step.last_byte = last_byte;

    always_comb begin
        case (state)
            iic_pkg::ST_DEV_WR,
            iic_pkg::ST_DEV_RD: last_bit = 4'd9; // start, 8 bits, ack
            iic_pkg::ST_STOP:   last_bit = 4'd0; // single bit
            default:            last_bit = 4'd8; // 8 bits, ack
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            iic_pkg::ST_IDLE:
                if (start)
                    state_nxt = iic_pkg::ST_DEV_WR;
            iic_pkg::ST_DEV_WR:
                if (field_end)
                    state_nxt = iic_pkg::ST_WORD_ADDR;
            iic_pkg::ST_WORD_ADDR:
                if (field_end)
                    state_nxt = (op == iic_pkg::OP_READ) ? iic_pkg::ST_DEV_RD :
                                                          iic_pkg::ST_WR_DATA;
            iic_pkg::ST_WR_DATA:
                if (field_end && last_byte)
                    state_nxt = iic_pkg::ST_STOP;
            iic_pkg::ST_DEV_RD:
                if (field_end)
                    state_nxt = iic_pkg::ST_RD_DATA;
            iic_pkg::ST_RD_DATA:
                if (field_end && last_byte)
                    state_nxt = iic_pkg::ST_STOP;
            iic_pkg::ST_STOP:
                if (field_end)
                    state_nxt = iic_pkg::ST_IDLE;
            default:
                state_nxt = iic_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst)
            state <= iic_pkg::ST_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst)
            bit_cnt <= '0;
        else if (state == iic_pkg::ST_IDLE || field_end)
            bit_cnt <= '0;               // every field starts at bit 0
        else if (phase_end)
            bit_cnt <= bit_cnt + 1'b1;
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst)
            byte_cnt <= '0;
        else if (!data_field)
            byte_cnt <= '0;
        else if (field_end)
            byte_cnt <= last_byte ? 2'd0 : byte_cnt + 1'b1;
    end

endmodule

//--- hdl/iic_bus_shifter.sv
// I2C bus shifter
// drives scl and the open-drain sda pull, shifts bytes and checks slave acks

module iic_bus_shifter #(
    parameter logic [6:0] DEVICE_ADDR = 7'h50
) (
    input  logic                       iic_clk,
    input  logic                       iic_rst,
    input  iic_pkg::iic_phase_t        phase,
    input  iic_pkg::iic_step_t         step,
    input  logic [7:0]                 word_addr,
    input  logic [iic_pkg::DATA_W-1:0] wdata,
    output logic                       scl,
    output logic                       sda_pull_low, // high pulls the line to 0
    input  logic                       sda_in,
    output logic [iic_pkg::DATA_W-1:0] rdata,
    output logic                       ack_error
);

    logic [7:0] dev_byte;  // device address plus r/w bit
    logic [7:0] tx_byte;   // word address or current data byte
    logic       ack_slot;  // slave answers in this bit
    logic       start_bit; // scl stays high here
    logic       was_idle;

    assign dev_byte  = {DEVICE_ADDR, step.state == iic_pkg::ST_DEV_RD};
    assign tx_byte   = (step.state == iic_pkg::ST_WORD_ADDR) ? word_addr :
                       wdata[(iic_pkg::DATA_BYTES - 1 - step.byte_cnt) * 8 +: 8];
    assign start_bit = (step.state == iic_pkg::ST_DEV_WR) && (step.bit_cnt == 4'd0);

    always_comb begin
        case (step.state)
            iic_pkg::ST_DEV_WR,
            iic_pkg::ST_DEV_RD:    ack_slot = (step.bit_cnt == 4'd9);
            iic_pkg::ST_WORD_ADDR,
            iic_pkg::ST_WR_DATA:   ack_slot = (step.bit_cnt == 4'd8);
            default:               ack_slot = 1'b0;
        endcase
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst)
            scl <= 1'b1;
        else if (step.state == iic_pkg::ST_IDLE || phase.scl_rise)
            scl <= 1'b1;
        else if (phase.scl_fall && !start_bit)
            scl <= 1'b0;
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            sda_pull_low <= 1'b0;
        end else begin
            case (step.state)
                iic_pkg::ST_DEV_WR, iic_pkg::ST_DEV_RD: begin
                    if (phase.drive) begin
                        if (step.bit_cnt == 4'd0)
                            sda_pull_low <= start_bit;   // start edge, or release first
                        else if (ack_slot)
                            sda_pull_low <= 1'b0;
                        else
                            sda_pull_low <= !dev_byte[3'(4'd8 - step.bit_cnt)];
                    end else if (phase.sample && step.bit_cnt == 4'd0) begin
                        sda_pull_low <= 1'b1;            // falling sda with scl high
                    end
                end
                iic_pkg::ST_WORD_ADDR, iic_pkg::ST_WR_DATA: begin
                    if (phase.drive)
                        sda_pull_low <= !ack_slot && !tx_byte[3'(4'd7 - step.bit_cnt)];
                end
                iic_pkg::ST_RD_DATA: begin
                    if (phase.drive)                     // master ack, nack on last byte
                        sda_pull_low <= (step.bit_cnt == 4'd8) && !step.last_byte;
                end
                iic_pkg::ST_STOP: begin
                    if (phase.drive)
                        sda_pull_low <= 1'b1;            // low while scl low
                    else if (phase.sample)
                        sda_pull_low <= 1'b0;            // rising sda with scl high
                end
                default: sda_pull_low <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst)
            rdata <= '0;
        else if (step.state == iic_pkg::ST_RD_DATA && phase.sample && step.bit_cnt < 4'd8)
            rdata <= {rdata[iic_pkg::DATA_W-2:0], sda_in}; // msb first
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst) begin
            was_idle  <= 1'b1;
            ack_error <= 1'b0;
        end else begin
            was_idle <= (step.state == iic_pkg::ST_IDLE);
            if (was_idle && step.state != iic_pkg::ST_IDLE)
                ack_error <= 1'b0;                       // new transaction
            else if (phase.sample && ack_slot && sda_in)
                ack_error <= 1'b1;                       // sticky until next start
        end
    end

endmodule

//--- hdl/iic_master.sv
// I2C EEPROM master top level
// latches one host command, runs the req/ack handshake, wires the bus stages

module iic_master #(
    parameter int         SYS_CLK_HZ  = 4_000_000,
    parameter int         SCL_HZ      = 250_000,
    parameter logic [6:0] DEVICE_ADDR = 7'h50
) (
    input  logic              iic_clk,
    input  logic              iic_rst,
    input  logic              req,
    input  iic_pkg::iic_cmd_t cmd,
    output logic              ack,
    output iic_pkg::iic_rsp_t rsp,
    output logic              scl,
    output logic              sda_pull_low,
    input  logic              sda_in
);

    iic_pkg::iic_cmd_t          cmd_q;     // command held for the whole transaction
    iic_pkg::iic_phase_t        phase;
    iic_pkg::iic_step_t         step;
    logic                       bit_end;
    logic                       run;
    logic                       start;
    logic                       done;
    logic [iic_pkg::DATA_W-1:0] rdata;
    logic                       ack_error;

    // new command only when idle and the previous ack has dropped
    assign start = req && !ack && (step.state == iic_pkg::ST_IDLE);

    always_ff @(posedge iic_clk) begin
        if (start)
            cmd_q <= cmd;
    end

    always_ff @(posedge iic_clk or negedge iic_rst) begin
        if (!iic_rst)
            ack <= 1'b0;
        else if (done)
            ack <= 1'b1;  // end of stop condition
        else if (!req)
            ack <= 1'b0;  // host finished the handshake
    end

    assign rsp.rdata     = rdata;
    assign rsp.ack_error = ack_error;

    iic_bit_timer #(
        .SYS_CLK_HZ(SYS_CLK_HZ),
        .SCL_HZ    (SCL_HZ)
    ) u_bit_timer (
        .iic_clk(iic_clk),
        .iic_rst(iic_rst),
        .run    (run),
        .phase  (phase),
        .bit_end(bit_end)
    );

    iic_sequencer u_sequencer (
        .iic_clk  (iic_clk),
        .iic_rst  (iic_rst),
        .start    (start),
        .op       (cmd_q.op),
        .phase_end(bit_end),
        .run      (run),
        .step     (step),
        .done     (done)
    );

    iic_bus_shifter #(
        .DEVICE_ADDR(DEVICE_ADDR)
    ) u_bus_shifter (
        .iic_clk     (iic_clk),
        .iic_rst     (iic_rst),
        .phase       (phase),
        .step        (step),
        .word_addr   (cmd_q.word_addr),
        .wdata       (cmd_q.wdata),
        .scl         (scl),
        .sda_pull_low(sda_pull_low),
        .sda_in      (sda_in),
        .rdata       (rdata),
        .ack_error   (ack_error)
    );

endmodule

//--- verification/eeprom_model.sv
// behavioral I2C EEPROM slave, 256 bytes, auto-incrementing address
// sits on the open-drain bus; nack_all makes it ignore every transfer

module eeprom_model #(
    parameter logic [6:0] DEVICE_ADDR = 7'h50
) (
    input  logic scl,
    input  logic sda,          // resolved bus level
    input  logic nack_all,     // never ack
    output logic sda_pull_low
);

    typedef enum logic [2:0] {M_IDLE, M_DEV, M_ADDR, M_WDATA, M_RDATA} mode_e;

    logic [7:0] mem [256];
    mode_e      mode;
    logic [3:0] cnt;      // scl rises inside the byte frame
    logic [7:0] shreg;    // received byte, or byte being sent
    logic [7:0] addr;
    logic       rd;       // read bit of the device byte
    logic       nacked;   // master nack after a read byte
    logic       scl_q;
    logic       sda_q;

    initial begin
        logic [8:0] i;
        for (i = 9'd0; i < 9'd256; i++)
            mem[i[7:0]] = i[7:0] ^ 8'hA5;          // power-up pattern
        mode = M_IDLE;
        cnt = 4'd0;
        shreg = 8'h00;
        addr = 8'h00;
        rd = 1'b0;
        nacked = 1'b0;
        sda_pull_low = 1'b0;
        scl_q = 1'b1;
        sda_q = 1'b1;
        forever begin
            @(scl or sda);
            if (scl && scl_q && sda_q && !sda) begin      // start or repeated start
                mode = M_DEV;
                cnt = 4'd0;
                sda_pull_low = 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin  // stop
                mode = M_IDLE;
                sda_pull_low = 1'b0;
            end else if (scl && !scl_q && mode != M_IDLE) begin
                if (mode == M_RDATA && cnt == 4'd8)
                    nacked = sda;                         // master ack slot
                else if (mode != M_RDATA && cnt < 4'd8)
                    shreg = {shreg[6:0], sda};            // msb first
                cnt = cnt + 1'b1;
            end else if (!scl && scl_q && mode == M_RDATA) begin
                if (cnt == 4'd9 && nacked) begin
                    mode = M_IDLE;                        // last byte done
                    sda_pull_low = 1'b0;
                end else if (cnt == 4'd9) begin
                    cnt = 4'd0;
                    shreg = mem[addr];
                    addr = addr + 1'b1;
                    sda_pull_low = !shreg[7];
                end else if (cnt == 4'd8) begin
                    sda_pull_low = 1'b0;                  // let the master answer
                end else if (cnt != 4'd0) begin
                    shreg = {shreg[6:0], 1'b1};
                    sda_pull_low = !shreg[7];
                end
            end else if (!scl && scl_q && mode != M_IDLE) begin
                if (cnt == 4'd8) begin
                    if (nack_all || (mode == M_DEV && shreg[7:1] != DEVICE_ADDR)) begin
                        mode = M_IDLE;                    // not for us
                    end else begin
                        if (mode == M_DEV)
                            rd = shreg[0];
                        else if (mode == M_ADDR)
                            addr = shreg;
                        else begin
                            mem[addr] = shreg;
                            addr = addr + 1'b1;
                        end
                        sda_pull_low = 1'b1;              // ack
                    end
                end else if (cnt == 4'd9) begin
                    cnt = 4'd0;
                    sda_pull_low = 1'b0;
                    if (mode == M_DEV && rd) begin
                        mode = M_RDATA;
                        shreg = mem[addr];
                        addr = addr + 1'b1;
                        sda_pull_low = !shreg[7];
                    end else if (mode == M_DEV)
                        mode = M_ADDR;
                    else
                        mode = M_WDATA;
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

//--- verification/iic_master_assert.sv
// protocol checks bound into the I2C master
// handshake order, response hold while acked, idle clock level

module iic_master_assert (
    input logic               iic_clk,
    input logic               iic_rst,
    input logic               req,
    input logic               ack,
    input iic_pkg::iic_rsp_t  rsp,
    input logic               scl,
    input iic_pkg::iic_step_t step
);

    // ack only answers a pending request
    ack_after_req: assert property (@(posedge iic_clk) disable iff (!iic_rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    rsp_held: assert property (@(posedge iic_clk) disable iff (!iic_rst)
        ack && $past(ack) |-> $stable(rsp))
        else $error("rsp changed while ack was high");

    // bus clock parked high between transactions
    scl_idle_high: assert property (@(posedge iic_clk) disable iff (!iic_rst)
        step.state == iic_pkg::ST_IDLE |-> scl)
        else $error("scl low while the sequencer was idle");

endmodule

bind iic_master iic_master_assert u_assert (
    .iic_clk(iic_clk),
    .iic_rst(iic_rst),
    .req    (req),
    .ack    (ack),
    .rsp    (rsp),
    .scl    (scl),
    .step   (step)
);

//--- verification/tb_iic_master.sv
// testbench for the I2C EEPROM master
// applies a command table over req/ack and checks responses against a reference memory

module tb_iic_master;

    localparam int         SYS_CLK_HZ  = 4_000_000;
    localparam int         SCL_HZ      = 250_000;
    localparam logic [6:0] DEVICE_ADDR = 7'h50;
    localparam int         N_FIXED     = 6;
    localparam int         N_ENTRIES   = N_FIXED + 24; // random part in write/read pairs
    localparam int         TIMEOUT     = 2000;         // cycles, a read needs 768

    typedef struct packed {
        iic_pkg::iic_op_e           op;
        logic [7:0]                 word_addr;
        logic [iic_pkg::DATA_W-1:0] wdata;
        logic                       nack_all;
        logic [iic_pkg::DATA_W-1:0] exp_rdata;     // reads only
        logic                       exp_ack_error;
    } entry_t;

    // op, word_addr, wdata, nack_all, exp_rdata, exp_ack_error
    localparam entry_t FIXED [N_FIXED] = '{
        '{iic_pkg::OP_WRITE, 8'h3C, 16'hBEEF, 1'b0, 16'h0000, 1'b0},
        '{iic_pkg::OP_READ,  8'h3C, 16'h0000, 1'b0, 16'hBEEF, 1'b0}, // read back
        '{iic_pkg::OP_READ,  8'h80, 16'h0000, 1'b0, 16'h2524, 1'b0}, // never written
        '{iic_pkg::OP_WRITE, 8'h10, 16'h1234, 1'b1, 16'h0000, 1'b1}, // slave silent
        '{iic_pkg::OP_READ,  8'h10, 16'h0000, 1'b1, 16'hFFFF, 1'b1},
        '{iic_pkg::OP_READ,  8'h10, 16'h0000, 1'b0, 16'hB5B4, 1'b0}  // error cleared
    };

    logic              iic_clk;
    logic              iic_rst;
    logic              req;
    iic_pkg::iic_cmd_t cmd;
    logic              ack;
    iic_pkg::iic_rsp_t rsp;
    logic              scl;
    logic              dut_pull;
    logic              eeprom_pull;
    logic              sda;
    logic              nack_all;
    logic [31:0]       lfsr;
    logic [7:0]        ref_mem [256];
    entry_t            entries [N_ENTRIES];

    assign sda = !(dut_pull || eeprom_pull); // open-drain wired-and

    iic_master #(
        .SYS_CLK_HZ (SYS_CLK_HZ),
        .SCL_HZ     (SCL_HZ),
        .DEVICE_ADDR(DEVICE_ADDR)
    ) DUT (
        .iic_clk     (iic_clk),
        .iic_rst     (iic_rst),
        .req         (req),
        .cmd         (cmd),
        .ack         (ack),
        .rsp         (rsp),
        .scl         (scl),
        .sda_pull_low(dut_pull),
        .sda_in      (sda)
    );

    eeprom_model #(
        .DEVICE_ADDR(DEVICE_ADDR)
    ) u_eeprom (
        .scl         (scl),
        .sda         (sda),
        .nack_all    (nack_all),
        .sda_pull_low(eeprom_pull)
    );

    always #10 iic_clk = !iic_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0); // galois, right shift
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]}; // one step per bit
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic store_ref(input logic [7:0] a, input logic [iic_pkg::DATA_W-1:0] d);
        int b;
        for (b = 0; b < iic_pkg::DATA_BYTES; b++)
            ref_mem[a + 8'(b)] = d[iic_pkg::DATA_W - 8 * (b + 1) +: 8]; // high byte first
    endtask

    function automatic logic [iic_pkg::DATA_W-1:0] read_ref(input logic [7:0] a);
        logic [iic_pkg::DATA_W-1:0] d;
        int                         b;
        d = '0;
        for (b = 0; b < iic_pkg::DATA_BYTES; b++)
            d = {d[iic_pkg::DATA_W-9:0], ref_mem[a + 8'(b)]};
        return d;
    endfunction

    task automatic build_table();
        logic [31:0]                r;
        logic [7:0]                 addr;
        logic [iic_pkg::DATA_W-1:0] data;
        logic [8:0]                 a;
        int                         i;
        for (a = 9'd0; a < 9'd256; a++)
            ref_mem[a[7:0]] = a[7:0] ^ 8'hA5;
        for (i = 0; i < N_FIXED; i++) begin
            entries[i] = FIXED[i];
            if (FIXED[i].op == iic_pkg::OP_WRITE && !FIXED[i].nack_all)
                store_ref(FIXED[i].word_addr, FIXED[i].wdata);
        end
        for (i = N_FIXED; i < N_ENTRIES; i += 2) begin
            take_bits(8, r);
            addr = r[7:0];
            take_bits(iic_pkg::DATA_W, r);
            data = r[iic_pkg::DATA_W-1:0];
            entries[i] = '{iic_pkg::OP_WRITE, addr, data, 1'b0, '0, 1'b0};
            store_ref(addr, data);
            take_bits(1, r);
            if (!r[0]) begin               // otherwise read the same address back
                take_bits(8, r);
                addr = r[7:0];
            end
            entries[i + 1] = '{iic_pkg::OP_READ, addr, '0, 1'b0, read_ref(addr), 1'b0};
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_rdata(input int idx, input iic_pkg::iic_rsp_t got,
                                 input logic [iic_pkg::DATA_W-1:0] exp);
        if (got.rdata !== exp)
            abort_run($sformatf("Fail rsp.rdata entry %0d got 0x%h expected 0x%h",
                                idx, got.rdata, exp));
    endtask

    task automatic verify_ack_error(input int idx, input iic_pkg::iic_rsp_t got,
                                    input logic exp);
        if (got.ack_error !== exp)
            abort_run($sformatf("Fail rsp.ack_error entry %0d got 0x%h expected 0x%h",
                                idx, got.ack_error, exp));
    endtask

    task automatic expect_bus_idle(input string where);
        if (ack !== 1'b0)
            abort_run($sformatf("Fail ack %s got 0x%h expected 0x0", where, ack));
        if (scl !== 1'b1)
            abort_run($sformatf("Fail scl %s got 0x%h expected 0x1", where, scl));
        if (dut_pull !== 1'b0)
            abort_run($sformatf("Fail sda_pull_low %s got 0x%h expected 0x0", where, dut_pull));
    endtask

    task automatic await_ack(input int idx);
        int cycles;
        cycles = 0;
        while (ack !== 1'b1) begin
            @(negedge iic_clk);
            cycles++;
            if (cycles > TIMEOUT)
                abort_run($sformatf("master gave no ack within %0d cycles on entry %0d",
                                    TIMEOUT, idx));
        end
    endtask

    task automatic await_ack_release(input int idx);
        int cycles;
        cycles = 0;
        while (ack !== 1'b0) begin
            @(negedge iic_clk);
            cycles++;
            if (cycles > TIMEOUT)
                abort_run($sformatf("ack stayed high after req fell on entry %0d", idx));
        end
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        e = entries[idx];
        @(negedge iic_clk);
        nack_all      = e.nack_all;
        cmd.op        = e.op;
        cmd.word_addr = e.word_addr;
        cmd.wdata     = e.wdata;
        req           = 1'b1;
        await_ack(idx);
        if (e.op == iic_pkg::OP_READ)
            compare_rdata(idx, rsp, e.exp_rdata);
        verify_ack_error(idx, rsp, e.exp_ack_error);
        repeat (2) begin                 // host holds req, master stalls with ack high
            @(negedge iic_clk);
            if (ack !== 1'b1)
                abort_run($sformatf("Fail ack entry %0d got 0x%h expected 0x1", idx, ack));
        end
        req = 1'b0;
        await_ack_release(idx);
        expect_bus_idle($sformatf("after entry %0d", idx));
    endtask

    initial begin
        int n;
        iic_clk  = 1'b0;
        iic_rst  = 1'b0;
        req      = 1'b0;
        cmd      = '0;
        nack_all = 1'b0;
        lfsr     = 32'h1ae7_f358;
        build_table();
        repeat (8) @(negedge iic_clk);
        iic_rst = 1'b1;
        @(negedge iic_clk);
        expect_bus_idle("after reset");
        for (n = 0; n < N_ENTRIES; n++)
            run_entry(n);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- verilog.f
hdl/iic_pkg.sv
hdl/iic_bit_timer.sv
hdl/iic_sequencer.sv
hdl/iic_bus_shifter.sv
hdl/iic_master.sv
verification/eeprom_model.sv
verification/iic_master_assert.sv
verification/tb_iic_master.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_iic_master \
    -f verilog.f -o sim_tb_iic_master &&
./obj_dir/sim_tb_iic_master ||
exit 1
